// ==== Makefile ====
VERILATOR  := verilator
TOP        := unified_mem_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
PASS_MSG   := TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== byte_store.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte-banked storage shared by fetch and load/store
// one write port, two read ports, all on the rising edge of sclk
module byte_store
   import mem_geom_pkg::*;
#(
   parameter int ADDR_W    = 8,
   parameter int MEM_BYTES = 256
)
(
   input  logic              sclk,
   data_port_if.store        dp,
   input  logic [ADDR_W-1:0] fetch_addr,
   output word_t             fetch_word
);

   localparam int BW = $bits(byte_t);

   // the array itself, contents undefined until written
   byte_t mem [MEM_BYTES];

   // per-lane byte addresses for each port
   logic [ADDR_W-1:0] fetch_idx [BYTES_PER_WORD];
   logic [ADDR_W-1:0] data_idx  [BYTES_PER_WORD];

   // lane i lives at base + i
   // the adds are ADDR_W wide so an access near the top wraps to byte 0
   always_comb
   begin
      for (int i = 0; i < BYTES_PER_WORD; i++)
      begin
         fetch_idx[i] = fetch_addr + ADDR_W'(i);
         data_idx[i]  = dp.addr + ADDR_W'(i);
      end
   end

   // write port
   // only enabled lanes change, the rest of the word keeps its bytes
   always_ff @(posedge sclk)
   begin
      for (int i = 0; i < BYTES_PER_WORD; i++)
      begin
         if (dp.we && dp.lane_en[i])
         begin
            mem[data_idx[i]] <= dp.wdata[BW*i +: BW];
         end
      end
   end

   // fetch read port, registered every cycle
   // a write in the same cycle is not visible yet, old bytes come back
   always_ff @(posedge sclk)
   begin
      for (int i = 0; i < BYTES_PER_WORD; i++)
      begin
         fetch_word[BW*i +: BW] <= mem[fetch_idx[i]];
      end
   end

   // data read port, same address as the write port
   // load/store unit decides if the word is needed
   always_ff @(posedge sclk)
   begin
      for (int i = 0; i < BYTES_PER_WORD; i++)
      begin
         dp.rdata[BW*i +: BW] <= mem[data_idx[i]];
      end
   end

endmodule

`default_nettype wire

// ==== data_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// data side port of the byte store
// one combined address serves both the write and the registered read
interface data_port_if
   import mem_geom_pkg::*;
#(
   parameter int ADDR_W = 8
);

   // store strobe, write lands on the next rising edge
   logic              we;
   // byte address with the data-region offset already applied
   logic [ADDR_W-1:0] addr;
   // lanes written when we is high
   lane_en_t          lane_en;
   // store data, lane 0 goes to addr
   word_t             wdata;
   // four bytes from addr upward, one cycle after addr
   word_t             rdata;

   // load/store unit side
   modport requester (output we, addr, lane_en, wdata, input rdata);

   // byte store side
   modport store (input we, addr, lane_en, wdata, output rdata);

endinterface

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// instruction fetch side
// tracks the request in flight and decodes the returned word
module fetch_unit
   import mem_geom_pkg::*;
#(
   parameter int ADDR_W = 8
)
(
   input  logic              sclk,
   input  logic              rst,
   input  logic              fetch_req,
   input  logic [ADDR_W-1:0] fetch_addr,
   input  word_t             fetch_word,
   output logic              fetch_valid,
   output word_t             fetch_inst,
   output logic              fetch_compressed,
   output logic [ADDR_W-1:0] fetch_next_addr
);

   // request strobe delayed to line up with the store's read latency
   logic              req_q;
   // address of the fetch in flight
   logic [ADDR_W-1:0] addr_q;
   // pc increment for the returned instruction
   logic [ADDR_W-1:0] step;

   always_ff @(posedge sclk)
   begin
      if (rst)
         req_q <= 1'b0;
      else
         req_q <= fetch_req;
   end

   // keep the address of the request being answered next cycle
   always_ff @(posedge sclk)
   begin
      if (fetch_req)
         addr_q <= fetch_addr;
   end

   assign fetch_valid = req_q;

   // full word goes out, upper half is don't care for a 16-bit instruction
   assign fetch_inst = fetch_word;

   // rv32c: opcode bits 1:0 == 2'b11 only for 32-bit encodings
   assign fetch_compressed = (fetch_word[1:0] != 2'b11);

   // +2 for compressed, +4 otherwise
   assign step = fetch_compressed ? ADDR_W'(2) : ADDR_W'(4);

   // wraps at the top of the address space
   assign fetch_next_addr = addr_q + step;

endmodule

`default_nettype wire

// ==== flist.f ====
mem_geom_pkg.sv
mem_access_pkg.sv
data_port_if.sv
byte_store.sv
fetch_unit.sv
load_store_unit.sv
unified_mem.sv
tb_clock_gen.sv
unified_mem_tb.sv

// ==== load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// data side
// offsets the address, builds byte enables, extends loaded values
module load_store_unit
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
#(
   parameter int ADDR_W      = 8,
   parameter int DATA_OFFSET = 100
)
(
   input  logic              sclk,
   input  logic              rst,
   input  logic              data_req,
   input  logic              data_we,
   input  access_size_e      data_size,
   input  load_ext_e         data_ext,
   input  logic [ADDR_W-1:0] data_addr,
   input  word_t             data_wdata,
   data_port_if.requester    dp,
   output logic              load_valid,
   output word_t             load_data
);

   // data-region base folded to the address width
   localparam logic [ADDR_W-1:0] OFFSET = ADDR_W'(DATA_OFFSET);

   // offset address, wraps modulo the memory size
   logic [ADDR_W-1:0] eff_addr;
   // lanes touched by this access size
   lane_en_t          size_lanes;

   // load request in flight
   logic              valid_q;
   // size and extension of the load in flight
   access_size_e      size_q;
   load_ext_e         ext_q;

   // top bit of the loaded value, zero for unsigned loads
   logic              sign_bit;

   assign eff_addr = data_addr + OFFSET;

   // word all four, half lanes 1:0, byte lane 0, invalid nothing
   always_comb
   begin
      case (data_size)
         SIZE_WORD: size_lanes = 4'b1111;
         SIZE_HALF: size_lanes = 4'b0011;
         SIZE_BYTE: size_lanes = 4'b0001;
         default:   size_lanes = 4'b0000;
      endcase
   end

   // request goes straight to the store in the same cycle
   assign dp.we      = data_req && data_we;
   assign dp.addr    = eff_addr;
   assign dp.lane_en = size_lanes;
   // lane 0 of wdata lands at eff_addr, upper lanes unused for sb/sh
   assign dp.wdata   = data_wdata;

   // only loads produce a response
   always_ff @(posedge sclk)
   begin
      if (rst)
         valid_q <= 1'b0;
      else
         valid_q <= data_req && !data_we;
   end

   // remember how to shape the word that comes back
   always_ff @(posedge sclk)
   begin
      if (data_req && !data_we)
      begin
         size_q <= data_size;
         ext_q  <= data_ext;
      end
   end

   assign load_valid = valid_q;

   // bit 7 for lb, bit 15 for lh
   always_comb
   begin
      sign_bit = 1'b0;
      if (ext_q == EXT_SIGN)
      begin
         if (size_q == SIZE_BYTE)
            sign_bit = dp.rdata[7];
         else if (size_q == SIZE_HALF)
            sign_bit = dp.rdata[15];
      end
   end

   // keep the low 1, 2 or 4 bytes and fill above them
   always_comb
   begin
      case (size_q)
         SIZE_WORD: load_data = dp.rdata;
         SIZE_HALF: load_data = {{16{sign_bit}}, dp.rdata[15:0]};
         SIZE_BYTE: load_data = {{24{sign_bit}}, dp.rdata[7:0]};
         // invalid size reads back as zero
         default:   load_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== mem_access_pkg.sv ====
`default_nettype none

// encodings of the load/store instructions seen by the data side
package mem_access_pkg;

   // access size, same codes as the core's funct3-derived select
   // word 0, half 1, byte 2, anything else is treated as invalid
   typedef enum logic [1:0] {
      SIZE_WORD    = 2'd0,
      SIZE_HALF    = 2'd1,
      SIZE_BYTE    = 2'd2,
      SIZE_INVALID = 2'd3
   } access_size_e;

   // load extension kind
   // zero for lbu/lhu, sign for lb/lh, ignored for lw and stores
   typedef enum logic {
      EXT_ZERO = 1'b0,
      EXT_SIGN = 1'b1
   } load_ext_e;

endpackage

`default_nettype wire

// ==== mem_geom_pkg.sv ====
`default_nettype none

// storage geometry shared by the byte store and both access sides
package mem_geom_pkg;

   // one addressable location of the store
   localparam int BYTE_W = 8;

   // byte lanes per 32-bit word, lane 0 is the lowest address
   localparam int BYTES_PER_WORD = 4;

   // full word width follows from the lane count
   localparam int WORD_W = BYTE_W * BYTES_PER_WORD;

   // single storage byte
   typedef logic [BYTE_W-1:0] byte_t;

   // little endian word, byte at addr sits in bits 7:0
   typedef logic [WORD_W-1:0] word_t;

   // one write enable per byte lane
   typedef logic [BYTES_PER_WORD-1:0] lane_en_t;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running clock plus a reset held over the first few cycles
module tb_clock_gen
#(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 4
)
(
   output logic sclk,
   output logic rst
);

   initial
   begin
      sclk = 1'b0;
      forever #(PERIOD_NS / 2) sclk = ~sclk;
   end

   // release on a falling edge, like every other input of the DUT
   initial
   begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge sclk);
      @(negedge sclk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// unified byte-addressed memory for the core
// fetch and load/store run side by side on one shared byte store
module unified_mem
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
#(
   parameter int ADDR_W      = 8,
   parameter int MEM_BYTES   = 256,
   parameter int DATA_OFFSET = 100
)
(
   input  logic              sclk,
   input  logic              rst,

   // instruction fetch
   input  logic              fetch_req,
   input  logic [ADDR_W-1:0] fetch_addr,
   output logic              fetch_valid,
   output word_t             fetch_inst,
   output logic              fetch_compressed,
   output logic [ADDR_W-1:0] fetch_next_addr,

   // loads and stores
   input  logic              data_req,
   input  logic              data_we,
   input  access_size_e      data_size,
   input  load_ext_e         data_ext,
   input  logic [ADDR_W-1:0] data_addr,
   input  word_t             data_wdata,
   output logic              load_valid,
   output word_t             load_data
);

   // registered word at fetch_addr, one cycle after the request
   word_t fetch_word;

   // load/store unit to byte store
   data_port_if #(.ADDR_W(ADDR_W)) dp_if ();

   // fetch side
   fetch_unit #(
      .ADDR_W (ADDR_W)
   ) u_fetch_unit (
      .sclk             (sclk),
      .rst              (rst),
      .fetch_req        (fetch_req),
      .fetch_addr       (fetch_addr),
      .fetch_word       (fetch_word),
      .fetch_valid      (fetch_valid),
      .fetch_inst       (fetch_inst),
      .fetch_compressed (fetch_compressed),
      .fetch_next_addr  (fetch_next_addr)
   );

   // data side, applies the data-region offset
   load_store_unit #(
      .ADDR_W      (ADDR_W),
      .DATA_OFFSET (DATA_OFFSET)
   ) u_load_store_unit (
      .sclk       (sclk),
      .rst        (rst),
      .data_req   (data_req),
      .data_we    (data_we),
      .data_size  (data_size),
      .data_ext   (data_ext),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .dp         (dp_if.requester),
      .load_valid (load_valid),
      .load_data  (load_data)
   );

   // shared storage, fetch reads raw addresses, data side reads offset ones
   byte_store #(
      .ADDR_W    (ADDR_W),
      .MEM_BYTES (MEM_BYTES)
   ) u_byte_store (
      .sclk       (sclk),
      .dp         (dp_if.store),
      .fetch_addr (fetch_addr),
      .fetch_word (fetch_word)
   );

endmodule

`default_nettype wire

// ==== unified_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// table driven testbench for the unified memory
// expected values come from a byte model kept next to the table
module unified_mem_tb
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
();

   localparam int ADDR_W       = 8;
   localparam int MEM_BYTES    = 256;
   localparam int DATA_OFFSET  = 100;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int TABLE_MAX    = 48;
   // four clocks per table slot plus reset and some slack
   localparam int WATCHDOG_NS  = (TABLE_MAX * 4 + RESET_CYCLES + 20) * CLK_PERIOD;

   typedef enum logic [2:0] {
      OP_IDLE,
      OP_STORE,
      OP_LOAD,
      OP_FETCH,
      OP_STORE_FETCH
   } op_e;

   logic              sclk;
   logic              rst;
   logic              fetch_req;
   logic [ADDR_W-1:0] fetch_addr;
   logic              fetch_valid;
   word_t             fetch_inst;
   logic              fetch_compressed;
   logic [ADDR_W-1:0] fetch_next_addr;
   logic              data_req;
   logic              data_we;
   access_size_e      data_size;
   load_ext_e         data_ext;
   logic [ADDR_W-1:0] data_addr;
   word_t             data_wdata;
   logic              load_valid;
   word_t             load_data;

   // reference copy of the memory
   byte_t             model_mem [MEM_BYTES];

   // stimulus table, one slot per test
   string             t_name  [TABLE_MAX];
   op_e               t_op    [TABLE_MAX];
   access_size_e      t_size  [TABLE_MAX];
   load_ext_e         t_ext   [TABLE_MAX];
   logic [ADDR_W-1:0] t_addr  [TABLE_MAX];
   word_t             t_wdata [TABLE_MAX];
   word_t             t_exp   [TABLE_MAX];

   int                n_entries;
   int                n_errors;
   int                n_failed;
   integer            seed;

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) clk_gen_inst (
      .sclk (sclk),
      .rst  (rst)
   );

   unified_mem #(
      .ADDR_W      (ADDR_W),
      .MEM_BYTES   (MEM_BYTES),
      .DATA_OFFSET (DATA_OFFSET)
   ) unified_mem_inst (
      .sclk             (sclk),
      .rst              (rst),
      .fetch_req        (fetch_req),
      .fetch_addr       (fetch_addr),
      .fetch_valid      (fetch_valid),
      .fetch_inst       (fetch_inst),
      .fetch_compressed (fetch_compressed),
      .fetch_next_addr  (fetch_next_addr),
      .data_req         (data_req),
      .data_we          (data_we),
      .data_size        (data_size),
      .data_ext         (data_ext),
      .data_addr        (data_addr),
      .data_wdata       (data_wdata),
      .load_valid       (load_valid),
      .load_data        (load_data)
   );

   // four model bytes from a upward in little endian order, wrapping at the top
   function automatic word_t model_word(input logic [ADDR_W-1:0] a);
      word_t w;
      for (int k = 0; k < BYTES_PER_WORD; k++)
         w[8*k +: 8] = model_mem[a + ADDR_W'(k)];
      return w;
   endfunction

   // invalid size writes nothing
   task automatic model_write(input logic [ADDR_W-1:0] a, input access_size_e s,
                              input word_t wd);
      int n;
      case (s)
         SIZE_WORD: n = 4;
         SIZE_HALF: n = 2;
         SIZE_BYTE: n = 1;
         default:   n = 0;
      endcase
      for (int k = 0; k < n; k++)
         model_mem[a + ADDR_W'(k)] = wd[8*k +: 8];
   endtask

   // low bytes kept and upper bits copy bit 7 or bit 15 only for signed loads
   function automatic word_t expected_load(input logic [ADDR_W-1:0] a,
                                           input access_size_e s, input load_ext_e e);
      word_t w;
      word_t r;
      w = model_word(a);
      r = '0;
      case (s)
         SIZE_WORD: r = w;
         SIZE_HALF:
         begin
            r[15:0] = w[15:0];
            if (e == EXT_SIGN && w[15])
               r[31:16] = '1;
         end
         SIZE_BYTE:
         begin
            r[7:0] = w[7:0];
            if (e == EXT_SIGN && w[7])
               r[31:8] = '1;
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   // expected value is taken from the model before a store updates it
   task automatic add_entry(input string name, input op_e op, input access_size_e s,
                            input load_ext_e e, input logic [ADDR_W-1:0] a,
                            input word_t wd);
      logic [ADDR_W-1:0] eff;
      eff = a + ADDR_W'(DATA_OFFSET);
      t_name[n_entries]  = name;
      t_op[n_entries]    = op;
      t_size[n_entries]  = s;
      t_ext[n_entries]   = e;
      t_addr[n_entries]  = a;
      t_wdata[n_entries] = wd;
      t_exp[n_entries]   = '0;
      case (op)
         OP_STORE: model_write(eff, s, wd);
         OP_LOAD:  t_exp[n_entries] = expected_load(eff, s, e);
         // fetch addresses are raw without the data-region offset
         OP_FETCH: t_exp[n_entries] = model_word(a);
         OP_STORE_FETCH:
         begin
            t_exp[n_entries] = model_word(eff);
            model_write(eff, s, wd);
         end
         default: t_exp[n_entries] = '0;
      endcase
      n_entries++;
   endtask

   task automatic build_table();
      // valids must stay low with nothing requested
      add_entry("idle_reset0", OP_IDLE, SIZE_WORD, EXT_ZERO, 8'd0, 32'h0);
      add_entry("idle_reset1", OP_IDLE, SIZE_WORD, EXT_ZERO, 8'd0, 32'h0);
      // random words at data 0..19 which are bytes 100..119
      for (int k = 0; k < 5; k++)
         add_entry($sformatf("sw_fill%0d", k), OP_STORE, SIZE_WORD, EXT_ZERO,
                   ADDR_W'(4 * k), $random(seed));
      add_entry("lw_fill0", OP_LOAD, SIZE_WORD, EXT_ZERO, 8'd0, 32'h0);
      add_entry("sw_a", OP_STORE, SIZE_WORD, EXT_ZERO, 8'd24, 32'h1357_9bdf);
      add_entry("lw_a", OP_LOAD, SIZE_WORD, EXT_ZERO, 8'd24, 32'h0);
      // upper wdata lanes are junk and must not land
      add_entry("sb_merge", OP_STORE, SIZE_BYTE, EXT_ZERO, 8'd8, 32'hffff_ffa5);
      add_entry("sh_merge", OP_STORE, SIZE_HALF, EXT_ZERO, 8'd10, 32'h1234_beef);
      add_entry("lw_merge", OP_LOAD, SIZE_WORD, EXT_ZERO, 8'd8, 32'h0);
      add_entry("sb_neg", OP_STORE, SIZE_BYTE, EXT_ZERO, 8'd16, 32'h0000_0085);
      add_entry("lb_neg", OP_LOAD, SIZE_BYTE, EXT_SIGN, 8'd16, 32'h0);
      add_entry("lbu_neg", OP_LOAD, SIZE_BYTE, EXT_ZERO, 8'd16, 32'h0);
      add_entry("sh_neg", OP_STORE, SIZE_HALF, EXT_ZERO, 8'd20, 32'h0000_8001);
      add_entry("lh_neg", OP_LOAD, SIZE_HALF, EXT_SIGN, 8'd20, 32'h0);
      add_entry("lhu_neg", OP_LOAD, SIZE_HALF, EXT_ZERO, 8'd20, 32'h0);
      add_entry("lb_hi", OP_LOAD, SIZE_BYTE, EXT_SIGN, 8'd21, 32'h0);
      add_entry("sh_pos", OP_STORE, SIZE_HALF, EXT_ZERO, 8'd28, 32'hffff_7ffe);
      add_entry("lh_pos", OP_LOAD, SIZE_HALF, EXT_SIGN, 8'd28, 32'h0);
      add_entry("sx_invalid", OP_STORE, SIZE_INVALID, EXT_ZERO, 8'd0, 32'hffff_ffff);
      add_entry("lw_after_inv", OP_LOAD, SIZE_WORD, EXT_ZERO, 8'd0, 32'h0);
      add_entry("lx_invalid", OP_LOAD, SIZE_INVALID, EXT_SIGN, 8'd0, 32'h0);
      // data 40 is fetch 140 and so on
      add_entry("sw_comp", OP_STORE, SIZE_WORD, EXT_ZERO, 8'd40, 32'h1234_5601);
      add_entry("if_comp", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd140, 32'h0);
      add_entry("sw_full", OP_STORE, SIZE_WORD, EXT_ZERO, 8'd44, 32'h00c0_ffef);
      add_entry("if_full", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd144, 32'h0);
      add_entry("if_fill0", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd100, 32'h0);
      // data 154 lands on byte 254 and spills into bytes 0 and 1
      add_entry("sw_wrap", OP_STORE, SIZE_WORD, EXT_ZERO, 8'd154, 32'ha5a5_0013);
      add_entry("if_wrap", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd254, 32'h0);
      add_entry("lw_wrap", OP_LOAD, SIZE_WORD, EXT_ZERO, 8'd154, 32'h0);
      add_entry("sh_wrap", OP_STORE, SIZE_HALF, EXT_ZERO, 8'd154, 32'h0000_4402);
      add_entry("if_wrap_c", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd254, 32'h0);
      // same-cycle fetch sees the old word and the next one the new word
      add_entry("sw_old", OP_STORE, SIZE_WORD, EXT_ZERO, 8'd48, 32'h1111_1111);
      add_entry("stf_same", OP_STORE_FETCH, SIZE_WORD, EXT_ZERO, 8'd48, 32'h2222_2223);
      add_entry("if_after", OP_FETCH, SIZE_WORD, EXT_ZERO, 8'd148, 32'h0);
      add_entry("idle_end", OP_IDLE, SIZE_WORD, EXT_ZERO, 8'd0, 32'h0);
   endtask

   function automatic logic [ADDR_W-1:0] fetch_addr_of(input int i);
      if (t_op[i] == OP_STORE_FETCH)
         return t_addr[i] + ADDR_W'(DATA_OFFSET);
      return t_addr[i];
   endfunction

   task automatic drive_entry(input int i);
      fetch_req  = 1'b0;
      data_req   = 1'b0;
      data_we    = 1'b0;
      data_size  = t_size[i];
      data_ext   = t_ext[i];
      data_addr  = t_addr[i];
      data_wdata = t_wdata[i];
      fetch_addr = fetch_addr_of(i);
      case (t_op[i])
         OP_STORE:
         begin
            data_req = 1'b1;
            data_we  = 1'b1;
         end
         OP_LOAD:  data_req = 1'b1;
         OP_FETCH: fetch_req = 1'b1;
         OP_STORE_FETCH:
         begin
            data_req  = 1'b1;
            data_we   = 1'b1;
            fetch_req = 1'b1;
         end
         default: fetch_req = 1'b0;
      endcase
   endtask

   task automatic compare_word(input string name, input string what, input word_t exp,
                               input word_t act);
      if (act !== exp)
      begin
         n_errors++;
         $display("Mismatch %s %s: expected %h actual %h", name, what, exp, act);
      end
   endtask

   // called one cycle after the entry was driven
   task automatic check_entry(input int i);
      int                errs_before;
      logic              want_load;
      logic              want_fetch;
      logic              comp;
      logic [ADDR_W-1:0] next_addr;
      errs_before = n_errors;
      want_load   = (t_op[i] == OP_LOAD);
      want_fetch  = (t_op[i] == OP_FETCH) || (t_op[i] == OP_STORE_FETCH);
      if (load_valid !== want_load)
      begin
         n_errors++;
         if (want_load)
            $display("test %s: load_valid missing one cycle after the load", t_name[i]);
         else
            $display("test %s: load_valid high with no load in flight", t_name[i]);
      end
      else if (want_load)
         compare_word(t_name[i], "load_data", t_exp[i], load_data);
      if (fetch_valid !== want_fetch)
      begin
         n_errors++;
         if (want_fetch)
            $display("test %s: fetch_valid missing one cycle after the fetch", t_name[i]);
         else
            $display("test %s: fetch_valid high with no fetch in flight", t_name[i]);
      end
      else if (want_fetch)
      begin
         // 16-bit encodings are the ones whose low two bits are not 11
         comp      = (t_exp[i][1:0] != 2'b11);
         next_addr = fetch_addr_of(i) + (comp ? 8'd2 : 8'd4);
         compare_word(t_name[i], "fetch_inst", t_exp[i], fetch_inst);
         compare_word(t_name[i], "fetch_compressed", 32'(comp), 32'(fetch_compressed));
         compare_word(t_name[i], "fetch_next_addr", 32'(next_addr), 32'(fetch_next_addr));
      end
      if (n_errors == errs_before)
         $display("test %-14s ok", t_name[i]);
      else
      begin
         n_failed++;
         $display("test %-14s failed", t_name[i]);
      end
   endtask

   initial
   begin
      seed       = 33;
      n_entries  = 0;
      n_errors   = 0;
      n_failed   = 0;
      // a fetch and a load are held up over the whole reset
      fetch_req  = 1'b1;
      fetch_addr = '0;
      data_req   = 1'b1;
      data_we    = 1'b0;
      data_size  = SIZE_WORD;
      data_ext   = EXT_ZERO;
      data_addr  = '0;
      data_wdata = '0;
      build_table();
      // the falling edge that ends reset
      repeat (RESET_CYCLES) @(posedge sclk);
      @(negedge sclk);
      if (load_valid !== 1'b0 || fetch_valid !== 1'b0)
      begin
         n_errors++;
         n_failed++;
         $display("test reset_hold: a valid came out of a request made during reset");
         $display("test %-14s failed", "reset_hold");
      end
      else
         $display("test %-14s ok", "reset_hold");
      // entries run back to back and each is checked on the next falling edge
      for (int i = 0; i < n_entries; i++)
      begin
         drive_entry(i);
         @(negedge sclk);
         check_entry(i);
      end
      fetch_req = 1'b0;
      data_req  = 1'b0;
      data_we   = 1'b0;
      @(negedge sclk);
      if (load_valid !== 1'b0 || fetch_valid !== 1'b0)
      begin
         n_errors++;
         $display("a valid was still high after the last request");
      end
      $display("%0d tests run, %0d failed, %0d errors", n_entries, n_failed, n_errors);
      if (n_errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the test table did not finish within %0d ns", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
